/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_sdram_check
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps
PASS_MSG  ?= Result: PASSED

.PHONY: sim clean

# Build, run, and fail unless the pass line shows up.
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)
	./$(OBJ_DIR)/V$(TOP) | awk -v msg="$(PASS_MSG)" \
		'{ print } index($$0, msg) { ok = 1 } END { exit !ok }'

clean:
	rm -rf $(OBJ_DIR)

/* flist.f */
source/sdram_check_pkg.sv
source/uart_frame_tx.sv
source/sdram_word_check.sv
source/sdram_check_seq.sv
source/sdram_check_top.sv
test/sdram_word_model.sv
test/sdram_check_props.sv
test/tb_sdram_check.sv

/* source/sdram_check_pkg.sv */
package sdram_check_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // SDRAM word port.
    ////////////////////////////////////////////////////////////////////////////
    localparam int addr_w = 24;                 // Bank 2 + row 13 + column 9.
    localparam int data_w = 16;                 // One SDRAM word.

    typedef logic [addr_w-1:0] sdram_addr_t;    // Word address.
    typedef logic [data_w-1:0] sdram_data_t;    // Word data.
    typedef logic [7:0]        uart_byte_t;     // One report byte.

    ////////////////////////////////////////////////////////////////////////////
    // Serial report line.
    ////////////////////////////////////////////////////////////////////////////
    localparam int baud_div   = 1157;           // 133.33 MHz / 115200 baud.
    localparam int frame_bits = 11;             // Start, 8 data, 2 stop.
    localparam int baud_cnt_w = $clog2(baud_div);
    localparam int bit_cnt_w  = $clog2(frame_bits);

    // Mismatch markers, sent in place of the read word.
    localparam uart_byte_t mark_high = 8'hEE;
    localparam uart_byte_t mark_low  = 8'hFF;

    ////////////////////////////////////////////////////////////////////////////
    // Pass length and pacing.
    ////////////////////////////////////////////////////////////////////////////
    localparam int default_word_count  = 384000;   // 480 x 800 frame buffer.
    localparam int default_pace_cycles = 2222222;  // Roughly 16.7 ms per word.
    localparam int pace_cnt_w          = 32;

    // Sequencer steps.
    localparam int step_w = 3;
    localparam logic [step_w-1:0] step_start = 3'd0;  // Issue check.
    localparam logic [step_w-1:0] step_check = 3'd1;  // Wait word result.
    localparam logic [step_w-1:0] step_high  = 3'd2;  // First frame on the line.
    localparam logic [step_w-1:0] step_low   = 3'd3;  // Second frame on the line.
    localparam logic [step_w-1:0] step_pace  = 3'd4;  // Pacing delay.
    localparam logic [step_w-1:0] step_halt  = 3'd5;  // Error halt, led on.
    localparam logic [step_w-1:0] step_stop  = 3'd6;  // Pass complete.

endpackage

/* source/sdram_check_seq.sv */
`timescale 1ns/1ps

module sdram_check_seq import sdram_check_pkg::*; #(
    parameter int word_count  = default_word_count,   // Words in one pass.
    parameter int pace_cycles = default_pace_cycles   // Delay after each report.
) (
    input  logic        clk_133MHz_210,
    input  logic        rst_n,

    // Word checker.
    output logic        check_start,
    output sdram_addr_t check_addr,
    output sdram_data_t check_data,
    input  logic        check_done,
    input  logic        check_match,
    input  sdram_data_t check_read_data,

    // UART transmitter.
    output logic        tx_start,
    output uart_byte_t  tx_byte,
    input  logic        tx_busy,

    output logic        led                            // Error halt.
);

    logic [step_w-1:0]     step;
    logic [pace_cnt_w-1:0] pace_cnt;
    uart_byte_t            low_byte;    // Second byte, waits out the first frame.
    logic                  failed;      // Current word mismatched.
    logic                  frame_end;   // Frame taken and finished.
    logic                  last_word;
    logic                  pace_end;

    // tx_busy rises only the cycle after tx_start, so the strobe itself
    // also counts as busy.
    assign frame_end = !tx_start && !tx_busy;
    assign last_word = (check_addr == addr_w'(word_count - 1));
    assign pace_end  = (pace_cnt == pace_cnt_w'(pace_cycles - 1));

    ////////////////////////////////////////////////////////////////////////////
    // Step sequencer.
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk_133MHz_210 or negedge rst_n) begin
        if (!rst_n) begin
            step        <= step_start;
            check_start <= 1'b0;
            check_addr  <= '0;
            check_data  <= '0;
            tx_start    <= 1'b0;
            failed      <= 1'b0;
            pace_cnt    <= '0;
            led         <= 1'b0;
        end else begin
            check_start <= 1'b0;               // Strobes default low.
            tx_start    <= 1'b0;
            case (step)
                step_start: begin
                    check_start <= 1'b1;       // Write and read back one word.
                    step        <= step_check;
                end
                step_check: begin
                    if (check_done) begin
                        failed   <= !check_match;
                        tx_start <= 1'b1;      // High byte or first marker.
                        step     <= step_high;
                    end
                end
                step_high: begin
                    if (frame_end) begin
                        tx_start <= 1'b1;      // Back to back.
                        step     <= step_low;
                    end
                end
                step_low: begin
                    if (frame_end) begin
                        if (failed) begin
                            led  <= 1'b1;
                            step <= step_halt;
                        end else begin
                            pace_cnt <= '0;
                            step     <= step_pace;
                        end
                    end
                end
                step_pace: begin
                    if (!pace_end) begin
                        pace_cnt <= pace_cnt + 1'b1;
                    end else if (last_word) begin
                        step <= step_stop;     // Pass done.
                    end else begin
                        check_addr <= check_addr + 1'b1;
                        check_data <= check_data + 1'b1;  // Wraps at 16 bits.
                        step       <= step_start;
                    end
                end
                step_halt: begin
                    led <= 1'b1;               // Stuck here until reset.
                end
                step_stop: begin
                    step <= step_stop;
                end
                default: begin
                    step <= step_stop;
                end
            endcase
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Report bytes.
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk_133MHz_210) begin
        if (step == step_check && check_done) begin
            // Read word on a match, markers otherwise.
            tx_byte  <= check_match ? check_read_data[data_w-1 -: 8] : mark_high;
            low_byte <= check_match ? check_read_data[7:0] : mark_low;
        end else if (step == step_high && frame_end) begin
            tx_byte <= low_byte;
        end
    end

endmodule

/* source/sdram_check_top.sv */
`timescale 1ns/1ps

module sdram_check_top import sdram_check_pkg::*; #(
    parameter int word_count  = default_word_count,
    parameter int pace_cycles = default_pace_cycles
) (
    input  logic        clk_133MHz_210,
    input  logic        rst_n,

    // SDRAM controller word port.
    output logic        write_req,
    output logic        read_req,
    output sdram_addr_t addr,
    output sdram_data_t write_data,
    input  logic        write_done,
    input  logic        read_done,
    input  sdram_data_t read_data,

    output logic        uart_txd,        // 115200 8N2.
    output logic        led              // High after a mismatch.
);

    // Sequencer to word checker.
    logic        check_start;
    sdram_addr_t check_addr;
    sdram_data_t check_data;
    logic        check_done;
    logic        check_match;
    sdram_data_t check_read_data;

    // Sequencer to UART.
    logic       tx_start;
    uart_byte_t tx_byte;
    logic       tx_busy;

    ////////////////////////////////////////////////////////////////////////////
    // Instances.
    ////////////////////////////////////////////////////////////////////////////
    sdram_check_seq #(
        .word_count  (word_count),
        .pace_cycles (pace_cycles)
    ) u_seq (
        .clk_133MHz_210  (clk_133MHz_210),
        .rst_n           (rst_n),
        .check_start     (check_start),
        .check_addr      (check_addr),
        .check_data      (check_data),
        .check_done      (check_done),
        .check_match     (check_match),
        .check_read_data (check_read_data),
        .tx_start        (tx_start),
        .tx_byte         (tx_byte),
        .tx_busy         (tx_busy),
        .led             (led)
    );

    sdram_word_check u_check (
        .clk_133MHz_210  (clk_133MHz_210),
        .rst_n           (rst_n),
        .check_start     (check_start),
        .check_addr      (check_addr),
        .check_data      (check_data),
        .check_done      (check_done),
        .check_match     (check_match),
        .check_read_data (check_read_data),
        .write_req       (write_req),
        .read_req        (read_req),
        .addr            (addr),
        .write_data      (write_data),
        .write_done      (write_done),
        .read_done       (read_done),
        .read_data       (read_data)
    );

    uart_frame_tx u_tx (
        .clk_133MHz_210 (clk_133MHz_210),
        .rst_n          (rst_n),
        .tx_start       (tx_start),
        .tx_byte        (tx_byte),
        .tx_busy        (tx_busy),
        .uart_txd       (uart_txd)
    );

endmodule

/* source/sdram_word_check.sv */
`timescale 1ns/1ps

module sdram_word_check import sdram_check_pkg::*; (
    input  logic        clk_133MHz_210,
    input  logic        rst_n,

    // Sequencer side.
    input  logic        check_start,      // One-cycle strobe.
    input  sdram_addr_t check_addr,       // Held until check_done.
    input  sdram_data_t check_data,       // Held until check_done.
    output logic        check_done,       // One-cycle result strobe.
    output logic        check_match,
    output sdram_data_t check_read_data,

    // Memory side, request level and done pulse.
    output logic        write_req,
    output logic        read_req,
    output sdram_addr_t addr,
    output sdram_data_t write_data,
    input  logic        write_done,
    input  logic        read_done,
    input  sdram_data_t read_data
);

    logic busy;        // A write or read leg is in flight.
    logic start_ok;    // New check accepted this cycle.
    logic write_fin;   // Write leg ends this cycle.
    logic read_fin;    // Read leg ends this cycle.

    assign busy      = write_req | read_req;
    assign start_ok  = check_start && !busy && !check_done;
    assign write_fin = write_req && write_done;
    assign read_fin  = read_req && read_done;

    ////////////////////////////////////////////////////////////////////////////
    // Port address and pattern.
    ////////////////////////////////////////////////////////////////////////////

    // Latched at start. Stable across both legs.
    always_ff @(posedge clk_133MHz_210) begin
        if (start_ok) begin
            addr       <= check_addr;
            write_data <= check_data;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Request FSM.
    // Idle, write leg, read leg, result. The state is carried by the two
    // requests and the done strobe, so at most one request is ever high.
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk_133MHz_210 or negedge rst_n) begin
        if (!rst_n) begin
            write_req  <= 1'b0;
            read_req   <= 1'b0;
            check_done <= 1'b0;
        end else begin
            check_done <= 1'b0;                // Strobe, one cycle only.
            if (start_ok) begin
                write_req <= 1'b1;             // Write leg first.
            end
            if (write_fin) begin
                write_req <= 1'b0;             // Drops the cycle after done.
                read_req  <= 1'b1;             // Read back the same address.
            end
            if (read_fin) begin
                read_req   <= 1'b0;
                check_done <= 1'b1;            // Result valid next cycle.
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Compare.
    ////////////////////////////////////////////////////////////////////////////

    // Read data is only valid in the done cycle.
    always_ff @(posedge clk_133MHz_210) begin
        if (read_fin) begin
            check_read_data <= read_data;
            check_match     <= (read_data == write_data);  // Against the written word.
        end
    end

endmodule

/* source/uart_frame_tx.sv */
`timescale 1ns/1ps

module uart_frame_tx import sdram_check_pkg::*; (
    input  logic       clk_133MHz_210,
    input  logic       rst_n,
    input  logic       tx_start,      // One-cycle strobe, only while idle.
    input  uart_byte_t tx_byte,
    output logic       tx_busy,
    output logic       uart_txd
);

    logic [frame_bits-1:0] shift_reg;   // Frame bits, LSB goes out first.
    logic [baud_cnt_w-1:0] baud_cnt;    // Cycles within one bit.
    logic [bit_cnt_w-1:0]  bit_cnt;     // Bit index within the frame.
    logic                  bit_end;     // Last cycle of the current bit.
    logic                  frame_last;  // Current bit is the second stop bit.

    assign bit_end    = (baud_cnt == baud_cnt_w'(baud_div - 1));
    assign frame_last = (bit_cnt == bit_cnt_w'(frame_bits - 1));

    ////////////////////////////////////////////////////////////////////////////
    // Frame shifter.
    ////////////////////////////////////////////////////////////////////////////

    // Stop bits on top, start bit at the bottom.
    always_ff @(posedge clk_133MHz_210) begin
        if (tx_start && !tx_busy) begin
            shift_reg <= {2'b11, tx_byte, 1'b0};
        end else if (tx_busy && bit_end) begin
            shift_reg <= {1'b1, shift_reg[frame_bits-1:1]};  // Fill with idle level.
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Baud and bit counters.
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk_133MHz_210 or negedge rst_n) begin
        if (!rst_n) begin
            tx_busy  <= 1'b0;
            baud_cnt <= '0;
            bit_cnt  <= '0;
        end else begin
            if (!tx_busy) begin
                if (tx_start) begin
                    tx_busy  <= 1'b1;          // Start bit goes out next cycle.
                    baud_cnt <= '0;
                    bit_cnt  <= '0;
                end
            end else if (bit_end) begin
                baud_cnt <= '0;
                if (frame_last) begin
                    tx_busy <= 1'b0;           // Frame over.
                    bit_cnt <= '0;
                end else begin
                    bit_cnt <= bit_cnt + 1'b1;
                end
            end else begin
                baud_cnt <= baud_cnt + 1'b1;
            end
        end
    end

    // Line idles high.
    assign uart_txd = tx_busy ? shift_reg[0] : 1'b1;

endmodule

/* test/sdram_check_props.sv */
`timescale 1ns/1ps

module sdram_check_props import sdram_check_pkg::*; (
    input logic        clk_133MHz_210,
    input logic        rst_n,
    input logic        write_req,
    input logic        read_req,
    input logic        write_done,
    input logic        read_done,
    input sdram_addr_t addr
);

    // One leg at a time.
    one_request: assert property (@(posedge clk_133MHz_210) disable iff (!rst_n)
        !(write_req && read_req))
        else $error("write_req and read_req high in the same cycle");

    write_holds: assert property (@(posedge clk_133MHz_210) disable iff (!rst_n)
        write_req && !write_done |=> write_req)
        else $error("write_req dropped before write_done");

    read_holds: assert property (@(posedge clk_133MHz_210) disable iff (!rst_n)
        read_req && !read_done |=> read_req)
        else $error("read_req dropped before read_done");

    // Write to read hand-over keeps the same word.
    addr_stable: assert property (@(posedge clk_133MHz_210) disable iff (!rst_n)
        (write_req || read_req) |=> (!write_req && !read_req) || $stable(addr))
        else $error("addr changed while a request was high");

endmodule

bind sdram_word_check sdram_check_props props (
    .clk_133MHz_210 (clk_133MHz_210),
    .rst_n          (rst_n),
    .write_req      (write_req),
    .read_req       (read_req),
    .write_done     (write_done),
    .read_done      (read_done),
    .addr           (addr)
);

/* test/sdram_word_model.sv */
`timescale 1ns/1ps

module sdram_word_model import sdram_check_pkg::*; (
    input  logic        clk_133MHz_210,
    input  logic        write_req,
    input  logic        read_req,
    input  sdram_addr_t addr,
    input  sdram_data_t write_data,
    output logic        write_done,
    output logic        read_done,
    output sdram_data_t read_data,
    input  logic        fault_en,       // Corrupt reads of one word.
    input  sdram_addr_t fault_addr,
    input  sdram_data_t fault_mask      // XOR applied on read.
);

    sdram_data_t mem [sdram_addr_t];    // Sparse word store.
    logic [31:0] rand_state = 32'd1;    // LCG seed.
    int          wait_cnt;
    bit          active;                // Latency drawn for the current request.

    // 32-bit LCG step.
    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1103515245 + 32'd12345;
    endfunction

    // Unwritten words read back a fill built from every address bit.
    function automatic sdram_data_t fill_word(input sdram_addr_t a);
        return a[15:0] ^ {8'h00, a[23:16]} ^ 16'hA5C3;
    endfunction

    initial begin
        write_done = 1'b0;
        read_done  = 1'b0;
        read_data  = '0;
        active     = 1'b0;
        wait_cnt   = 0;
        forever begin
            @(posedge clk_133MHz_210);
            #1;
            write_done = 1'b0;                  // Done is a single cycle.
            read_done  = 1'b0;
            if (!write_req && !read_req) begin
                active = 1'b0;
            end else begin
                if (!active) begin
                    rand_state = lcg_next(rand_state);
                    wait_cnt   = int'(rand_state[18:16]) + 1;  // 1 to 8 cycles.
                    active     = 1'b1;
                end
                wait_cnt = wait_cnt - 1;
                if (wait_cnt == 0) begin
                    active = 1'b0;              // Request drops at the next edge.
                    if (write_req) begin
                        mem[addr]  = write_data;
                        write_done = 1'b1;
                    end else begin
                        read_data = mem.exists(addr) ? mem[addr] : fill_word(addr);
                        if (fault_en && addr == fault_addr) begin
                            read_data = read_data ^ fault_mask;
                        end
                        read_done = 1'b1;
                    end
                end
            end
        end
    end

endmodule

/* test/tb_sdram_check.sv */
`timescale 1ns/1ps

module tb_sdram_check import sdram_check_pkg::*; ();

    localparam int tb_words    = 6;
    localparam int tb_pace     = 40;
    localparam int rows        = 4;
    localparam int slot_cycles = 2 * frame_bits * baud_div + tb_pace + 20;  // One word.
    localparam int cycle_limit = rows * tb_words * slot_cycles;

    // Scenario table. Fault rows corrupt one address on read.
    string       row_name  [rows] = '{"no_fault", "fault_at_3", "fault_at_0", "no_fault_again"};
    bit          row_fault [rows] = '{1'b0, 1'b1, 1'b1, 1'b0};
    sdram_addr_t row_addr  [rows] = '{24'd0, 24'd3, 24'd0, 24'd0};
    sdram_data_t row_mask  [rows] = '{16'h0000, 16'h8000, 16'h0001, 16'h0000};

    logic        clk_133MHz_210 = 1'b0;
    logic        rst_n;
    logic        write_req;
    logic        read_req;
    logic        write_done;
    logic        read_done;
    sdram_addr_t addr;
    sdram_addr_t fault_addr;
    sdram_data_t write_data;
    sdram_data_t read_data;
    sdram_data_t fault_mask;
    logic        fault_en;
    logic        uart_txd;
    logic        led;

    uart_byte_t rx_bytes [$];           // Every decoded byte of all rows.
    string      cur_name     = "reset";
    int         row_errors   = 0;
    int         port_errors  = 0;
    int         frame_errors = 0;
    int         write_index  = 0;       // Write requests seen this row.
    int         read_index   = 0;       // Read requests seen this row.
    bit         prev_write   = 1'b0;
    bit         prev_read    = 1'b0;
    bit         led_seen_high = 1'b0;
    int         cycle_cnt    = 0;

    always #50 clk_133MHz_210 = ~clk_133MHz_210;  // 100 ns period.

    sdram_check_top #(.word_count(tb_words), .pace_cycles(tb_pace)) dut (
        .clk_133MHz_210 (clk_133MHz_210),
        .rst_n          (rst_n),
        .write_req      (write_req),
        .read_req       (read_req),
        .addr           (addr),
        .write_data     (write_data),
        .write_done     (write_done),
        .read_done      (read_done),
        .read_data      (read_data),
        .uart_txd       (uart_txd),
        .led            (led)
    );

    sdram_word_model mem (
        .clk_133MHz_210 (clk_133MHz_210),
        .write_req      (write_req),
        .read_req       (read_req),
        .addr           (addr),
        .write_data     (write_data),
        .write_done     (write_done),
        .read_done      (read_done),
        .read_data      (read_data),
        .fault_en       (fault_en),
        .fault_addr     (fault_addr),
        .fault_mask     (fault_mask)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Compare tasks.
    ////////////////////////////////////////////////////////////////////////////
    task automatic check_byte(input string name, input uart_byte_t exp_val,
                              input uart_byte_t act_val);
        if (act_val !== exp_val) begin
            row_errors++;
            $display("ERROR %s: expected 0x%02h, actual 0x%02h", name, exp_val, act_val);
        end
    endtask

    task automatic check_addr(input string name, input sdram_addr_t exp_val,
                              input sdram_addr_t act_val);
        if (act_val !== exp_val) begin
            port_errors++;
            $display("ERROR %s: addr expected 0x%06h, actual 0x%06h",
                     name, exp_val, act_val);
        end
    endtask

    task automatic check_data(input string name, input sdram_data_t exp_val,
                              input sdram_data_t act_val);
        if (act_val !== exp_val) begin
            port_errors++;
            $display("ERROR %s: write data expected 0x%04h, actual 0x%04h",
                     name, exp_val, act_val);
        end
    endtask

    task automatic check_led(input string name, input bit exp_val, input logic act_val);
        if (act_val !== exp_val) begin
            row_errors++;
            $display("ERROR %s: led expected %0b, actual %0b", name, exp_val, act_val);
        end
    endtask

    task automatic print_counts;
        $display("Errors: %0d report, %0d port, %0d framing",
                 row_errors, port_errors, frame_errors);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Monitors.
    ////////////////////////////////////////////////////////////////////////////

    // UART receiver. Samples mid-bit on the falling clock edge.
    initial begin : uart_decoder
        uart_byte_t rx;
        int         i;
        forever begin
            @(negedge uart_txd);
            repeat (baud_div / 2) @(negedge clk_133MHz_210);
            if (uart_txd !== 1'b0) begin
                frame_errors++;
                $display("%s: start bit was not low at its middle", cur_name);
            end
            for (i = 0; i < 8; i++) begin
                repeat (baud_div) @(negedge clk_133MHz_210);
                rx = {uart_txd, rx[7:1]};   // LSB arrives first.
            end
            for (i = 0; i < 2; i++) begin
                repeat (baud_div) @(negedge clk_133MHz_210);
                if (uart_txd !== 1'b1) begin
                    frame_errors++;
                    $display("%s: stop bit %0d was not high", cur_name, i + 1);
                end
            end
            rx_bytes.push_back(rx);
        end
    end

    // Word port. Address and pattern both equal the word index.
    always @(negedge clk_133MHz_210) begin
        if (!rst_n) begin
            write_index   = 0;
            read_index    = 0;
            prev_write    = 1'b0;
            prev_read     = 1'b0;
            led_seen_high = 1'b0;
        end else begin
            if (write_req && !prev_write) begin
                check_addr({cur_name, " write"}, sdram_addr_t'(write_index), addr);
                check_data(cur_name, sdram_data_t'(write_index), write_data);
                write_index++;
            end
            if (read_req && !prev_read) begin
                check_addr({cur_name, " read"}, sdram_addr_t'(read_index), addr);
                read_index++;               // Reads back the word just written.
            end
            prev_write = write_req;
            prev_read  = read_req;
            if (led === 1'b1) begin
                led_seen_high = 1'b1;
            end
        end
    end

    // Hang guard.
    always @(posedge clk_133MHz_210) begin
        cycle_cnt++;
        if (cycle_cnt >= cycle_limit) begin
            $display("Run hung in %s: no end after %0d cycles", cur_name, cycle_cnt);
            print_counts();
            $display("Result: FAILED");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // One table row.
    ////////////////////////////////////////////////////////////////////////////
    task automatic run_row(input int row);
        uart_byte_t exp_q [$];
        bit         exp_led;
        int         k;
        int         base;
        int         got;
        exp_led = 1'b0;
        k       = 0;
        // Expected report from the word index alone.
        while (k < tb_words && !exp_led) begin
            if (row_fault[row] && sdram_addr_t'(k) == row_addr[row]) begin
                exp_q.push_back(mark_high);
                exp_q.push_back(mark_low);
                exp_led = 1'b1;             // Halts after the markers.
            end else begin
                exp_q.push_back(uart_byte_t'(k >> 8));
                exp_q.push_back(uart_byte_t'(k));
            end
            k++;
        end
        @(posedge clk_133MHz_210);
        #1;
        rst_n      = 1'b0;
        cur_name   = row_name[row];
        fault_en   = row_fault[row];
        fault_addr = row_addr[row];
        fault_mask = row_mask[row];
        base       = rx_bytes.size();
        repeat (10) @(posedge clk_133MHz_210);
        #1;
        rst_n = 1'b1;
        while (rx_bytes.size() - base < exp_q.size()) begin
            @(negedge clk_133MHz_210);
        end
        if (exp_led) begin
            while (led !== 1'b1) begin
                @(negedge clk_133MHz_210);
            end
        end
        repeat (slot_cycles) @(negedge clk_133MHz_210);  // Quiet window.
        got = rx_bytes.size() - base;
        if (got != exp_q.size()) begin
            row_errors++;
            $display("%s: %0d bytes received where %0d were expected",
                     cur_name, got, exp_q.size());
        end
        for (k = 0; k < exp_q.size() && k < got; k++) begin
            check_byte($sformatf("%s byte %0d", cur_name, k), exp_q[k], rx_bytes[base + k]);
        end
        check_led(cur_name, exp_led, led);
        if (!exp_led) begin
            check_led({cur_name, " led during run"}, 1'b0, led_seen_high);
        end
        if (write_index != exp_q.size() / 2 || read_index != exp_q.size() / 2) begin
            row_errors++;
            $display("%s: %0d writes and %0d reads seen where %0d of each were expected",
                     cur_name, write_index, read_index, exp_q.size() / 2);
        end
    endtask

    initial begin : main
        int row;
        rst_n      = 1'b0;
        fault_en   = 1'b0;
        fault_addr = '0;
        fault_mask = '0;
        for (row = 0; row < rows; row++) begin
            run_row(row);
        end
        print_counts();
        if (row_errors + port_errors + frame_errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule
